// ==== hw/csr_pkg.sv ====
package csr_pkg;

    // timer counter width
    localparam int TIMER_N = 20;
    // interrupt lines in ECFG/ESTAT, position 10 is reserved
    localparam int INT_N = 13;

    // request kind and subtypes
    localparam logic [3:0] KIND_PRIV   = 4'd3;
    localparam logic [4:0] SUB_ERTN    = 5'd6;
    localparam logic [4:0] SUB_CSRRD   = 5'd8;
    localparam logic [4:0] SUB_CSRWR   = 5'd9;
    localparam logic [4:0] SUB_CSRXCHG = 5'd10;

    // csr numbers
    localparam logic [13:0] CSR_CRMD   = 14'h000;
    localparam logic [13:0] CSR_PRMD   = 14'h001;
    localparam logic [13:0] CSR_EUEN   = 14'h002;
    localparam logic [13:0] CSR_ECFG   = 14'h004;
    localparam logic [13:0] CSR_ESTAT  = 14'h005;
    localparam logic [13:0] CSR_ERA    = 14'h006;
    localparam logic [13:0] CSR_BADV   = 14'h007;
    localparam logic [13:0] CSR_EENTRY = 14'h00c;
    localparam logic [13:0] CSR_SAVE0  = 14'h030;
    localparam logic [13:0] CSR_SAVE1  = 14'h031;
    localparam logic [13:0] CSR_SAVE2  = 14'h032;
    localparam logic [13:0] CSR_SAVE3  = 14'h033;
    localparam logic [13:0] CSR_TID    = 14'h040;
    localparam logic [13:0] CSR_TCFG   = 14'h041;
    localparam logic [13:0] CSR_TVAL   = 14'h042;
    localparam logic [13:0] CSR_TICLR  = 14'h044;

    localparam logic [5:0] ECODE_INT = 6'h00;
    localparam logic [5:0] ECODE_ADE = 6'h08;
    localparam logic [8:0] ESUB_ADEF = 9'h000;

    // argument word, csr number or exception report
    typedef union packed {
        struct packed {
            logic [1:0]  pad;
            logic [13:0] num;
        } csr;
        struct packed {
            logic       valid;
            logic [8:0] esubcode;
            logic [5:0] ecode;
        } excp;
    } csr_arg_u;

    typedef struct packed {
        logic [3:0]  kind;
        logic [4:0]  subtype;
        csr_arg_u    arg;
        logic [31:0] din;
        logic [31:0] mask;
        logic [31:0] pc;
    } csr_req_t;

    typedef struct packed {
        csr_arg_u    arg;
        logic [31:0] pc;
        logic [31:0] evaddr;
    } late_excp_t;

    typedef struct packed {
        logic        take_trap;
        logic        do_ertn;
        logic        do_write;
        logic [31:0] era;
        logic [5:0]  ecode;
        logic [8:0]  esubcode;
        logic [31:0] badv;
    } trap_cmd_t;

endpackage

// ==== hw/csr_trap_ctrl.sv ====
`timescale 1ns/1ps

module csr_trap_ctrl (
    input  csr_pkg::csr_req_t   req,
    input  logic [31:0]         evaddr,
    input  csr_pkg::late_excp_t late,
    input  logic                stall_in,
    input  logic                flush_in,
    input  logic                int_req,
    input  logic [31:0]         era,
    input  logic [25:0]         eentry,
    output logic                flush,
    output logic [31:0]         next_pc,
    output csr_pkg::trap_cmd_t  cmd
);
    import csr_pkg::*;

    logic is_priv;
    logic late_valid;
    logic accept;

    assign is_priv    = req.kind == KIND_PRIV;
    assign late_valid = late.arg.excp.valid;
    assign accept     = !stall_in && !flush_in && (is_priv || late_valid);

    always_comb
    begin
        cmd = '0;
        // interrupt wins even under stall
        if (int_req)
        begin
            cmd.take_trap = 1'b1;
            cmd.era       = req.pc;
            cmd.ecode     = ECODE_INT;
            cmd.esubcode  = '0;
            cmd.badv      = evaddr;
        end
        else if (accept && late_valid)
        begin
            cmd.take_trap = 1'b1;
            cmd.era       = late.pc;
            cmd.ecode     = late.arg.excp.ecode;
            cmd.esubcode  = late.arg.excp.esubcode;
            cmd.badv      = late.evaddr;
            // fetch fault reports the pc as bad address
            if (late.arg.excp.ecode == ECODE_ADE && late.arg.excp.esubcode == ESUB_ADEF)
            begin
                cmd.badv = late.pc;
            end
        end
        else if (accept && is_priv)
        begin
            case (req.subtype)
                SUB_ERTN:
                    cmd.do_ertn = 1'b1;
                SUB_CSRRD, SUB_CSRWR, SUB_CSRXCHG:
                    cmd.do_write = req.subtype != SUB_CSRRD;
                default:
                    cmd.do_write = 1'b0;
            endcase
        end

        if (cmd.take_trap)
        begin
            next_pc = {eentry, 6'b0};
        end
        else if (cmd.do_ertn)
        begin
            next_pc = era;
        end
        else
        begin
            next_pc = req.pc + 32'd4;
        end
        flush = cmd.take_trap || cmd.do_ertn || cmd.do_write;
    end

endmodule

// ==== hw/csr_regfile.sv ====
`timescale 1ns/1ps

module csr_regfile (
    input  logic                        clk,
    input  logic                        rstn,
    input  csr_pkg::csr_req_t           req,
    input  csr_pkg::trap_cmd_t          cmd,
    input  logic [8:0]                  hw_int,
    input  logic [csr_pkg::TIMER_N-1:0] tcfg,
    input  logic [csr_pkg::TIMER_N-1:0] tval,
    input  logic                        ti,
    output logic [31:0]                 dout,
    output logic [31:0]                 era,
    output logic [25:0]                 eentry,
    output logic [8:0]                  crmd,
    output logic                        int_req,
    output logic                        tcfg_we,
    output logic                        ti_clr,
    output logic [31:0]                 wdata
);
    import csr_pkg::*;

    logic [2:0]       prmd;
    logic             euen;
    logic [INT_N-1:0] ecfg;
    logic [1:0]       estat_is;
    logic [5:0]       estat_ecode;
    logic [8:0]       estat_esub;
    logic [31:0]      badv;
    logic [3:0][31:0] save;
    logic [31:0]      tid;
    logic [13:0]      num;
    logic [31:0]      mask;
    logic [INT_N-1:0] pending;

    assign num = req.arg.csr.num;

    // ipi, timer, reserved, hw lines, software bits
    assign pending = {hw_int[8], ti, 1'b0, hw_int[7:0], estat_is};
    assign int_req = crmd[2] && |(pending & ecfg);

    always_comb
    begin
        case (num)
            CSR_CRMD:   dout = {23'b0, crmd};
            CSR_PRMD:   dout = {29'b0, prmd};
            CSR_EUEN:   dout = {31'b0, euen};
            CSR_ECFG:   dout = 32'(ecfg);
            CSR_ESTAT:  dout = {1'b0, estat_esub, estat_ecode, 3'b0, pending};
            CSR_ERA:    dout = era;
            CSR_BADV:   dout = badv;
            CSR_EENTRY: dout = {eentry, 6'b0};
            CSR_SAVE0:  dout = save[0];
            CSR_SAVE1:  dout = save[1];
            CSR_SAVE2:  dout = save[2];
            CSR_SAVE3:  dout = save[3];
            CSR_TID:    dout = tid;
            CSR_TCFG:   dout = 32'(tcfg);
            CSR_TVAL:   dout = 32'(tval);
            default:    dout = '0;
        endcase
    end

    // csrwr behaves as an exchange with all mask bits set
    assign mask  = (req.subtype == SUB_CSRXCHG) ? req.mask : '1;
    assign wdata = (dout & ~mask) | (req.din & mask);

    assign tcfg_we = cmd.do_write && num == CSR_TCFG;
    assign ti_clr  = cmd.do_write && num == CSR_TICLR && wdata[0];

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd        <= 9'h008;
            prmd        <= '0;
            euen        <= 1'b0;
            ecfg        <= '0;
            estat_is    <= '0;
            estat_ecode <= '0;
            estat_esub  <= '0;
            era         <= '0;
            badv        <= '0;
            eentry      <= '0;
            save        <= '0;
            tid         <= '0;
        end
        else if (cmd.take_trap)
        begin
            prmd        <= crmd[2:0];
            crmd[2:0]   <= 3'b0;
            era         <= cmd.era;
            estat_ecode <= cmd.ecode;
            estat_esub  <= cmd.esubcode;
            badv        <= cmd.badv;
        end
        else if (cmd.do_ertn)
        begin
            // pg on, da off
            crmd[4:0] <= {2'b10, prmd};
        end
        else if (cmd.do_write)
        begin
            case (num)
                CSR_CRMD:
                begin
                    crmd[2:0] <= wdata[2:0];
                    crmd[8:5] <= wdata[8:5];
                    if (wdata[4] ^ wdata[3])
                    begin
                        crmd[4:3] <= wdata[4:3];
                    end
                end
                CSR_PRMD:   prmd <= wdata[2:0];
                CSR_EUEN:   euen <= wdata[0];
                CSR_ECFG:   ecfg <= {wdata[INT_N-1:11], 1'b0, wdata[9:0]};
                CSR_ESTAT:  estat_is <= wdata[1:0];
                CSR_ERA:    era <= wdata;
                CSR_BADV:   badv <= wdata;
                CSR_EENTRY: eentry <= wdata[31:6];
                CSR_SAVE0:  save[0] <= wdata;
                CSR_SAVE1:  save[1] <= wdata;
                CSR_SAVE2:  save[2] <= wdata;
                CSR_SAVE3:  save[3] <= wdata;
                CSR_TID:    tid <= wdata;
                // tcfg and ticlr land in the timer
                default:    tid <= tid;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!rstn) !(cmd.do_write && cmd.take_trap))
        else $error("csr write in a trap cycle");

endmodule

// ==== hw/csr_timer.sv ====
`timescale 1ns/1ps

module csr_timer (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        tcfg_we,
    input  logic [31:0]                 wdata,
    input  logic                        ti_clr,
    output logic [csr_pkg::TIMER_N-1:0] tcfg,
    output logic [csr_pkg::TIMER_N-1:0] tval,
    output logic                        ti
);
    import csr_pkg::*;

    logic en;
    logic periodic;

    assign en       = tcfg[0];
    assign periodic = tcfg[1];

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tcfg <= '0;
            tval <= '0;
            ti   <= 1'b0;
        end
        else
        begin
            // a config write restarts the count
            if (tcfg_we)
            begin
                tcfg <= wdata[TIMER_N-1:0];
                tval <= {wdata[TIMER_N-1:2], 2'b00};
            end
            else if (en && tval != '0)
            begin
                tval <= tval - 1'b1;
            end
            else if (en && periodic)
            begin
                tval <= {tcfg[TIMER_N-1:2], 2'b00};
            end

            if (ti_clr)
            begin
                ti <= 1'b0;
            end
            else if (en && tval == TIMER_N'(1))
            begin
                ti <= 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rstn)
        (en && !tcfg_we && !(periodic && tval == '0)) |=> tval <= $past(tval))
        else $error("tval rose without reload or write");

endmodule

// ==== hw/csr_top.sv ====
`timescale 1ns/1ps

module csr_top (
    input  logic                clk,
    input  logic                rstn,
    input  logic                stall_in,
    input  logic                flush_in,
    input  csr_pkg::csr_req_t   req,
    input  logic [31:0]         evaddr,
    input  csr_pkg::late_excp_t late,
    input  logic [8:0]          hw_int,
    output logic                flush,
    output logic [31:0]         next_pc,
    output logic [31:0]         dout,
    output logic [8:0]          crmd
);
    import csr_pkg::*;

    trap_cmd_t          cmd;
    logic [31:0]        era;
    logic [25:0]        eentry;
    logic               int_req;
    logic               tcfg_we;
    logic               ti_clr;
    logic [31:0]        wdata;
    logic [TIMER_N-1:0] tcfg;
    logic [TIMER_N-1:0] tval;
    logic               ti;

    csr_trap_ctrl trap_i (
        .req      (req),
        .evaddr   (evaddr),
        .late     (late),
        .stall_in (stall_in),
        .flush_in (flush_in),
        .int_req  (int_req),
        .era      (era),
        .eentry   (eentry),
        .flush    (flush),
        .next_pc  (next_pc),
        .cmd      (cmd)
    );

    csr_regfile regs_i (
        .clk     (clk),
        .rstn    (rstn),
        .req     (req),
        .cmd     (cmd),
        .hw_int  (hw_int),
        .tcfg    (tcfg),
        .tval    (tval),
        .ti      (ti),
        .dout    (dout),
        .era     (era),
        .eentry  (eentry),
        .crmd    (crmd),
        .int_req (int_req),
        .tcfg_we (tcfg_we),
        .ti_clr  (ti_clr),
        .wdata   (wdata)
    );

    csr_timer timer_i (
        .clk     (clk),
        .rstn    (rstn),
        .tcfg_we (tcfg_we),
        .wdata   (wdata),
        .ti_clr  (ti_clr),
        .tcfg    (tcfg),
        .tval    (tval),
        .ti      (ti)
    );

endmodule

// ==== verification/csr_checker.sv ====
`timescale 1ns/1ps

module csr_checker (
    input  logic        clk,
    // 0 idle, 1 check every output, 2 check next_pc once flush shows up
    input  logic [1:0]  mode,
    input  logic        check_crmd,
    input  logic [31:0] exp_dout,
    input  logic        exp_flush,
    input  logic [31:0] exp_next_pc,
    input  logic        flush,
    input  logic [31:0] next_pc,
    input  logic [31:0] dout,
    input  logic [8:0]  crmd,
    output int          errors
);

    initial errors = 0;

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        if (got !== want)
        begin
            $display("Mismatch at %0d ns: %s is %08h, expected %08h", $time, name, got, want);
            errors++;
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk)
    begin
        if (mode == 2'd1)
        begin
            compare_word("flush", 32'(flush), 32'(exp_flush));
            compare_word("next_pc", next_pc, exp_next_pc);
            compare_word("dout", dout, exp_dout);
            if (check_crmd)
            begin
                compare_word("crmd", 32'(crmd), exp_dout);
            end
        end
        else if (mode == 2'd2 && flush)
        begin
            compare_word("next_pc", next_pc, exp_next_pc);
        end
    end

endmodule

// ==== verification/csr_tb.sv ====
`timescale 1ns/1ps

module csr_tb;
    import csr_pkg::*;

    localparam int WAIT_LIMIT = 400;

    logic        clk;
    logic        rstn;
    logic        stall_in;
    logic        flush_in;
    csr_req_t    req;
    logic [31:0] evaddr;
    late_excp_t  late;
    logic [8:0]  hw_int;
    logic        flush;
    logic [31:0] next_pc;
    logic [31:0] dout;
    logic [8:0]  crmd;

    logic [1:0]  chk_mode;
    logic        check_crmd;
    logic [31:0] exp_dout;
    logic        exp_flush;
    logic [31:0] exp_next_pc;
    int          mismatches;
    int          other_errors;
    int          steps;
    int          seed;
    logic [31:0] rand_q[$];

    csr_top dut_i (
        .clk      (clk),
        .rstn     (rstn),
        .stall_in (stall_in),
        .flush_in (flush_in),
        .req      (req),
        .evaddr   (evaddr),
        .late     (late),
        .hw_int   (hw_int),
        .flush    (flush),
        .next_pc  (next_pc),
        .dout     (dout),
        .crmd     (crmd)
    );

    csr_checker chk_i (
        .clk         (clk),
        .mode        (chk_mode),
        .check_crmd  (check_crmd),
        .exp_dout    (exp_dout),
        .exp_flush   (exp_flush),
        .exp_next_pc (exp_next_pc),
        .flush       (flush),
        .next_pc     (next_pc),
        .dout        (dout),
        .crmd        (crmd),
        .errors      (mismatches)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // step type 0 plain, 1 random write, 2 random read, 3 wait for flush,
    // 4 under stall, 5 under flush
    task automatic run_step(input string line);
        logic [31:0] step, kind, sub, arg, din, mask, pc;
        logic [31:0] larg, lpc, ea, e_dout, e_flush, e_npc;
        int n;
        int cnt;
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h", step, kind, sub, arg,
                    din, mask, pc, larg, lpc, ea, e_dout, e_flush, e_npc);
        if (n != 13)
        begin
            $display("stimulus line has %0d fields instead of 13: %s", n, line);
            other_errors++;
            return;
        end
        if (step == 32'd1)
        begin
            din = $random(seed);
            rand_q.push_back(din);
        end
        if (step == 32'd2)
        begin
            if (rand_q.size() == 0)
            begin
                $display("read step has no random write before it");
                other_errors++;
            end
            else
            begin
                e_dout = rand_q.pop_front();
            end
        end
        @(posedge clk);
        req.kind    <= kind[3:0];
        req.subtype <= sub[4:0];
        req.arg     <= arg[15:0];
        req.din     <= din;
        req.mask    <= mask;
        req.pc      <= pc;
        late.arg    <= larg[15:0];
        late.pc     <= lpc;
        late.evaddr <= ea;
        evaddr      <= ea;
        stall_in    <= step == 32'd4;
        flush_in    <= step == 32'd5;
        chk_mode    <= (step == 32'd3) ? 2'd2 : 2'd1;
        // the CRMD read value is also the crmd output
        check_crmd  <= arg[13:0] == CSR_CRMD;
        exp_dout    <= e_dout;
        exp_flush   <= e_flush[0];
        exp_next_pc <= e_npc;
        if (step == 32'd3)
        begin
            cnt = 0;
            @(negedge clk);
            while (!flush && cnt < WAIT_LIMIT)
            begin
                @(negedge clk);
                cnt++;
            end
            if (!flush)
            begin
                $display("no flush within %0d cycles while waiting for a trap", WAIT_LIMIT);
                other_errors++;
            end
        end
    endtask

    initial
    begin
        int fd;
        string line;
        rstn         = 1'b0;
        stall_in     = 1'b0;
        flush_in     = 1'b0;
        req          = '0;
        late         = '0;
        evaddr       = '0;
        hw_int       = '0;
        chk_mode     = 2'd0;
        check_crmd   = 1'b0;
        exp_dout     = '0;
        exp_flush    = 1'b0;
        exp_next_pc  = '0;
        other_errors = 0;
        steps        = 0;
        seed         = 46;
        repeat (2) @(posedge clk);
        rstn <= 1'b1;

        fd = $fopen("verification/csr_testdata.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open the stimulus file");
            other_errors++;
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                if ($fgets(line, fd) != 0 && line.len() > 1 && line.getc(0) != "#")
                begin
                    run_step(line);
                    steps++;
                end
            end
            $fclose(fd);
        end
        if (steps == 0)
        begin
            $display("no steps were run");
            other_errors++;
        end

        @(posedge clk);
        req        <= '0;
        late       <= '0;
        chk_mode   <= 2'd0;
        check_crmd <= 1'b0;
        @(negedge clk);
        $display("%0d steps, %0d mismatches, %0d other errors", steps, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0)
        begin
            $display("all tests passed");
        end
        else
        begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== verification/csr_testdata.txt ====
# type kind subtype arg din mask pc late_arg late_pc evaddr exp_dout exp_flush exp_next_pc
# type 0 plain, 1 random write, 2 random read, 3 wait for flush, 4 stall_in, 5 flush_in
1 3 09 0030 00000000 00000000 1c000000 0000 00000000 00000000 00000000 1 1c000004
2 3 08 0030 00000000 00000000 1c000004 0000 00000000 00000000 00000000 0 1c000008
1 3 09 0031 00000000 00000000 1c000008 0000 00000000 00000000 00000000 1 1c00000c
2 3 08 0031 00000000 00000000 1c00000c 0000 00000000 00000000 00000000 0 1c000010
1 3 09 0032 00000000 00000000 1c000010 0000 00000000 00000000 00000000 1 1c000014
2 3 08 0032 00000000 00000000 1c000014 0000 00000000 00000000 00000000 0 1c000018
1 3 09 0033 00000000 00000000 1c000018 0000 00000000 00000000 00000000 1 1c00001c
2 3 08 0033 00000000 00000000 1c00001c 0000 00000000 00000000 00000000 0 1c000020
0 3 09 0040 12345678 00000000 1c000020 0000 00000000 00000000 00000000 1 1c000024
0 3 08 0040 00000000 00000000 1c000024 0000 00000000 00000000 12345678 0 1c000028
0 3 09 0006 1c0000a0 00000000 1c000028 0000 00000000 00000000 00000000 1 1c00002c
0 3 08 0006 00000000 00000000 1c00002c 0000 00000000 00000000 1c0000a0 0 1c000030
0 3 0a 0040 ffff0000 00ffff00 1c000030 0000 00000000 00000000 12345678 1 1c000034
0 3 08 0040 00000000 00000000 1c000034 0000 00000000 00000000 12ff0078 0 1c000038
0 3 09 0004 ffffffff 00000000 1c000038 0000 00000000 00000000 00000000 1 1c00003c
0 3 08 0004 00000000 00000000 1c00003c 0000 00000000 00000000 00001bff 0 1c000040
0 3 09 0000 ffffffff 00000000 1c000040 0000 00000000 00000000 00000008 1 1c000044
0 3 08 0000 00000000 00000000 1c000044 0000 00000000 00000000 000001ef 0 1c000048
0 3 09 000c 1c008040 00000000 1c000048 0000 00000000 00000000 00000000 1 1c00004c
0 0 00 0000 00000000 00000000 1c000100 8008 1c000200 deadbeef 000001ef 1 1c008040
0 3 08 0006 00000000 00000000 1c008040 0000 00000000 00000000 1c000200 0 1c008044
0 3 08 0005 00000000 00000000 1c008044 0000 00000000 00000000 00080000 0 1c008048
0 3 08 0007 00000000 00000000 1c008048 0000 00000000 00000000 1c000200 0 1c00804c
0 3 08 0001 00000000 00000000 1c00804c 0000 00000000 00000000 00000007 0 1c008050
0 3 08 0000 00000000 00000000 1c008050 0000 00000000 00000000 000001e8 0 1c008054
0 3 06 0000 00000000 00000000 1c008054 0000 00000000 00000000 000001e8 1 1c000200
0 3 08 0000 00000000 00000000 1c000200 0000 00000000 00000000 000001f7 0 1c000204
0 0 00 0000 00000000 00000000 1c000204 8009 1c000300 00001234 000001f7 1 1c008040
0 3 08 0007 00000000 00000000 1c008040 0000 00000000 00000000 00001234 0 1c008044
4 3 09 0040 0badf00d 00000000 1c008044 0000 00000000 00000000 12ff0078 0 1c008048
5 3 09 0040 0badf00d 00000000 1c008048 0000 00000000 00000000 12ff0078 0 1c00804c
0 3 08 0040 00000000 00000000 1c00804c 0000 00000000 00000000 12ff0078 0 1c008050
0 3 09 0004 00000800 00000000 1c008050 0000 00000000 00000000 00001bff 1 1c008054
0 3 09 0041 00000023 00000000 1c008054 0000 00000000 00000000 00000000 1 1c008058
0 3 09 0000 00000004 00000000 1c008058 0000 00000000 00000000 000001f0 1 1c00805c
3 0 00 0000 00000000 00000000 1c000400 0000 00000000 00000000 00000000 0 1c008040
0 3 08 0005 00000000 00000000 1c008040 0000 00000000 00000000 00000800 0 1c008044
0 3 08 0000 00000000 00000000 1c008044 0000 00000000 00000000 00000010 0 1c008048
0 3 09 0044 00000001 00000000 1c008048 0000 00000000 00000000 00000000 1 1c00804c
0 3 08 0005 00000000 00000000 1c00804c 0000 00000000 00000000 00000000 0 1c008050

// ==== project.f ====
hw/csr_pkg.sv
hw/csr_trap_ctrl.sv
hw/csr_regfile.sv
hw/csr_timer.sv
hw/csr_top.sv
verification/csr_checker.sv
verification/csr_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module csr_tb -o csr_sim

out=$(./obj_dir/csr_sim)
echo "$out"

if echo "$out" | grep -q "^all tests passed$"; then
    exit 0
fi
exit 1
